// ==== vlog.f ====
+incdir+hw
hw/core_pkg.sv
hw/ifu.sv
hw/regfile.sv
hw/idu.sv
hw/exu.sv
hw/core_top.sv
test/tb_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass message in the log
rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module tb_core -o tb_core_sim > build.log 2>&1 \
	|| { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== test/tb_core.sv ====
// testbench for core_top: program image, store memory, reference model, compare process, tests, watchdog
`include "core_cfg.svh"

module tb_core import core_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PROG_WORDS = 64;
	localparam int RESET_CYCLES = 5;
	localparam int CYCLES_PER_WORD = 40;
	localparam int WATCHDOG_MARGIN = 50;
	localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

	// expected effects of one retired instruction
	typedef struct packed {
		wb_t         wb;
		store_t      store;
		logic [31:0] next_pc;
		logic        halt;
	} iss_out_t;

	logic        clk;
	logic        rst_n;
	logic [31:0] inst;
	logic [31:0] inst_addr;
	wb_t         wb;
	store_t      store;
	logic        halted;

	logic [31:0] prog [PROG_WORDS];
	int          prog_len;
	logic [31:0] data_mem [logic [31:0]];

	// reference model state
	logic [31:0] ref_regs [32];
	logic [31:0] ref_pc;
	logic        ref_halted;

	integer seed;
	int     err_total;
	int     test_errs;
	int     tests_run;
	int     tests_failed;
	int     cycle_count;
	int     deadline = 200;
	string  cur_test;

	core_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.inst      (inst),
		.inst_addr (inst_addr),
		.wb        (wb),
		.store     (store),
		.halted    (halted)
	);

	// outside the image the core reads ebreak and stops
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - `CORE_RESET_PC;
		if (offset >= 32'(PROG_WORDS * 4)) begin
			return EBREAK_WORD;
		end
		return prog[offset[7:2]];
	endfunction

	assign inst = fetch_word(inst_addr);

	// store port goes into a sparse data memory
	always @(posedge clk) begin
		if (store.en) begin
			data_mem[store.addr] = store.data;
		end
	end

	function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b001_0011};
	endfunction

	function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b110_0111};
	endfunction

	function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b011_0111};
	endfunction

	function automatic logic [31:0] enc_auipc(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b001_0111};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
	endfunction

	function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b010_0011};
	endfunction

	// one instruction of the rv32 subset, straight from the isa rules
	function automatic iss_out_t iss_step(input logic [31:0] ins);
		iss_out_t    res;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [31:0] link;
		rd = ins[11:7];
		a = ref_regs[ins[19:15]];
		b = ref_regs[ins[24:20]];
		imm_i = 32'($signed(ins[31:20]));
		imm_s = 32'($signed({ins[31:25], ins[11:7]}));
		imm_u = {ins[31:12], 12'h000};
		imm_j = 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
		link = ref_pc + 32'd4;
		res = '0;
		res.wb.addr = rd;
		res.next_pc = link;
		case (ins[6:0])
			7'b001_0011: begin
				if (ins[14:12] == 3'b000) begin
					res.wb.en = 1'b1;
					res.wb.data = a + imm_i;
				end
			end
			7'b011_0111: begin
				res.wb.en = 1'b1;
				res.wb.data = imm_u;
			end
			7'b001_0111: begin
				res.wb.en = 1'b1;
				res.wb.data = ref_pc + imm_u;
			end
			7'b110_1111: begin
				res.wb.en = 1'b1;
				res.wb.data = link;
				res.next_pc = ref_pc + imm_j;
			end
			7'b110_0111: begin
				if (ins[14:12] == 3'b000) begin
					res.wb.en = 1'b1;
					res.wb.data = link;
					res.next_pc = (a + imm_i) & ~32'd1;
				end
			end
			7'b010_0011: begin
				if (ins[14:12] == 3'b010) begin
					res.store.en = 1'b1;
					res.store.addr = a + imm_s;
					res.store.data = b;
				end
			end
			7'b111_0011: begin
				if (ins == EBREAK_WORD) begin
					res.halt = 1'b1;
					res.next_pc = ref_pc;
				end
			end
			default: ;
		endcase
		if (res.wb.en && rd != 5'd0) begin
			ref_regs[rd] = res.wb.data;
		end
		ref_pc = res.next_pc;
		ref_halted = res.halt;
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h (test %s, %0t)", name, got, exp, cur_test,
				$time);
			err_total++;
			test_errs++;
		end
	endtask

	task automatic check_stored(input logic [31:0] addr, input logic [31:0] exp);
		if (!data_mem.exists(addr)) begin
			$display("no store to address 0x%h reached the memory model (test %s)", addr,
				cur_test);
			err_total++;
			test_errs++;
		end else begin
			check_value("data_mem", data_mem[addr], exp);
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
		prog_len = 0;
		for (int i = 0; i < PROG_WORDS; i++) begin
			prog[i[5:0]] = EBREAK_WORD;
		end
	endtask

	task automatic add_word(input logic [31:0] w);
		prog[prog_len[5:0]] = w;
		prog_len++;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs == 0) begin
			$display("test %-14s ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %-14s failed with %0d mismatches", cur_test, test_errs);
		end
	endtask

	// reset, release, wait for the halt, then watch the halted core a while
	task automatic run_program(input int hold_cycles);
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		// register file keeps its contents through reset
		ref_pc = `CORE_RESET_PC;
		ref_halted = 1'b0;
		deadline = cycle_count + RESET_CYCLES + CYCLES_PER_WORD * prog_len + hold_cycles
			+ WATCHDOG_MARGIN;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		while (halted !== 1'b1) @(negedge clk);
		repeat (hold_cycles) @(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// outputs are settled at the falling edge
	initial begin
		iss_out_t exp;
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				check_value("wb.en", {31'd0, wb.en}, 32'd0);
				check_value("store.en", {31'd0, store.en}, 32'd0);
			end else if (ref_halted) begin
				check_value("halted", {31'd0, halted}, 32'd1);
				check_value("inst_addr", inst_addr, ref_pc);
				check_value("wb.en", {31'd0, wb.en}, 32'd0);
				check_value("store.en", {31'd0, store.en}, 32'd0);
			end else begin
				check_value("inst_addr", inst_addr, ref_pc);
				check_value("halted", {31'd0, halted}, 32'd0);
				exp = iss_step(fetch_word(ref_pc));
				check_value("wb.en", {31'd0, wb.en}, {31'd0, exp.wb.en});
				if (exp.wb.en) begin
					check_value("wb.addr", {27'd0, wb.addr}, {27'd0, exp.wb.addr});
					check_value("wb.data", wb.data, exp.wb.data);
				end
				check_value("store.en", {31'd0, store.en}, {31'd0, exp.store.en});
				if (exp.store.en) begin
					check_value("store.addr", store.addr, exp.store.addr);
					check_value("store.data", store.data, exp.store.data);
				end
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count <= deadline) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: test %s did not halt within its budget of %0d cycles", cur_test,
			deadline);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rnd;
		int          kind;
		rst_n = 1'b0;
		seed = 79600;
		err_total = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < 32; i++) begin
			ref_regs[i[4:0]] = 32'd0;
		end

		start_test("addi_chain");
		add_word(enc_addi(5'd1, 5'd0, 12'd100));
		add_word(enc_addi(5'd2, 5'd1, 12'(-300)));
		add_word(enc_addi(5'd3, 5'd2, 12'd2047));
		add_word(enc_addi(5'd4, 5'd3, 12'(-2048)));
		// visible on wb, but x0 must still read zero
		add_word(enc_addi(5'd0, 5'd1, 12'd5));
		add_word(enc_addi(5'd5, 5'd0, 12'd7));
		add_word(EBREAK_WORD);
		run_program(2);
		finish_test();

		start_test("lui_auipc");
		add_word(enc_lui(5'd6, 20'hABCDE));
		add_word(enc_auipc(5'd7, 20'h12345));
		add_word(enc_auipc(5'd8, 20'h00001));
		add_word(enc_addi(5'd9, 5'd6, 12'(-1)));
		add_word(EBREAK_WORD);
		run_program(2);
		finish_test();

		// words 1 and 4 are jumped over
		start_test("jal_jalr");
		add_word(enc_jal(5'd1, 21'd12));
		add_word(enc_addi(5'd11, 5'd0, 12'd1));
		add_word(EBREAK_WORD);
		add_word(enc_jalr(5'd2, 5'd1, 12'd17));
		add_word(enc_addi(5'd12, 5'd0, 12'h055));
		add_word(enc_addi(5'd13, 5'd2, 12'd0));
		add_word(enc_jal(5'd3, 21'(-16)));
		run_program(2);
		finish_test();

		start_test("store_word");
		add_word(enc_addi(5'd1, 5'd0, 12'h100));
		add_word(enc_addi(5'd2, 5'd0, 12'(-5)));
		add_word(enc_sw(5'd2, 5'd1, 12'd8));
		add_word(enc_sw(5'd1, 5'd2, 12'(-4)));
		add_word(EBREAK_WORD);
		run_program(2);
		check_stored(32'h0000_0108, 32'hFFFF_FFFB);
		check_stored(32'hFFFF_FFF7, 32'h0000_0100);
		finish_test();

		// same image twice, the second run starts again from the reset pc
		start_test("ebreak_halt");
		add_word(enc_addi(5'd1, 5'd0, 12'd1));
		add_word(EBREAK_WORD);
		add_word(enc_addi(5'd2, 5'd0, 12'd2));
		run_program(8);
		finish_test();
		cur_test = "reset_reentry";
		test_errs = 0;
		run_program(3);
		finish_test();

		start_test("random_prog");
		for (int r = 1; r < 16; r++) begin
			rnd = $random(seed);
			add_word(enc_addi(r[4:0], 5'd0, rnd[11:0]));
		end
		for (int n = 0; n < 40; n++) begin
			rnd = $random(seed);
			kind = int'(rnd[2:0]) % 5;
			case (kind)
				0: add_word(enc_addi({1'b0, rnd[7:4]}, {1'b0, rnd[11:8]}, rnd[23:12]));
				1: add_word(enc_lui({1'b0, rnd[7:4]}, rnd[31:12]));
				2: add_word(enc_auipc({1'b0, rnd[7:4]}, rnd[31:12]));
				3: add_word(enc_sw({1'b0, rnd[7:4]}, {1'b0, rnd[11:8]}, rnd[23:12]));
				default: add_word(enc_jal({1'b0, rnd[7:4]}, 21'd8));
			endcase
		end
		// a jump at the end still lands on an ebreak
		add_word(EBREAK_WORD);
		add_word(EBREAK_WORD);
		run_program(2);
		finish_test();

		$display("summary: %0d tests run, %0d failed, %0d mismatches in total", tests_run,
			tests_failed, err_total);
		if (err_total == 0 && tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== hw/core_top.sv ====
// core top level: fetch, decode and execute units and their connections
`include "core_cfg.svh"

module core_top import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [31:0]           inst,
	output logic [`CORE_XLEN-1:0] inst_addr,
	output wb_t                   wb,
	output store_t                store,
	output logic                  halted
);

	// fetch side
	logic                  redirect;
	logic [`CORE_XLEN-1:0] target;
	logic                  is_ebreak;

	// decode to execute
	dec_to_exu_t           dec;

	// pc goes straight out as the fetch address
	ifu u_ifu (
		.clk       (clk),
		.rst_n     (rst_n),
		.redirect  (redirect),
		.target    (target),
		.is_ebreak (is_ebreak),
		.pc        (inst_addr),
		.halted    (halted)
	);

	// writeback loops back into the register file
	idu u_idu (
		.clk       (clk),
		.rst_n     (rst_n),
		.inst      (inst),
		.pc        (inst_addr),
		.wr        (wb),
		.dec       (dec),
		.is_ebreak (is_ebreak)
	);

	exu u_exu (
		.dec      (dec),
		.halted   (halted),
		.rst_n    (rst_n),
		.wb       (wb),
		.store    (store),
		.redirect (redirect),
		.target   (target)
	);

endmodule

// ==== hw/exu.sv ====
// execute unit with adder, link value, jump target, writeback and store routing
`include "core_cfg.svh"

module exu import core_pkg::*; (
	input  dec_to_exu_t           dec,
	input  logic                  halted,
	input  logic                  rst_n,
	output wb_t                   wb,
	output store_t                store,
	output logic                  redirect,
	output logic [`CORE_XLEN-1:0] target
);

	logic [`CORE_XLEN-1:0] sum;
	logic [`CORE_XLEN-1:0] link;
	logic [`CORE_XLEN-1:0] wb_data;
	logic                  wb_req;
	logic                  store_req;
	logic                  jump;
	logic                  active;

	// add is the only alu function
	assign sum = dec.src1 + dec.src2;

	// return address for jal and jalr
	assign link = dec.pc + `CORE_XLEN'(`CORE_INST_BYTES);

	always_comb begin
		wb_req    = 1'b0;
		wb_data   = sum;
		store_req = 1'b0;
		jump      = 1'b0;
		target    = sum;
		case (dec.cls)
			CLS_ADDI, CLS_LUI, CLS_AUIPC: wb_req = 1'b1;
			CLS_JAL: begin
				wb_req  = 1'b1;
				wb_data = link;
				jump    = 1'b1;
			end
			CLS_JALR: begin
				wb_req  = 1'b1;
				wb_data = link;
				jump    = 1'b1;
				// lsb of the jalr target is dropped
				target  = {sum[`CORE_XLEN-1:1], 1'b0};
			end
			CLS_SW:  store_req = 1'b1;
			default: ;
		endcase
	end

	// nothing retires in reset or after ebreak
	assign active = rst_n & ~halted;

	assign wb.en      = wb_req & active;
	assign wb.addr    = dec.rd;
	assign wb.data    = wb_data;

	assign store.en   = store_req & active;
	assign store.addr = sum;
	assign store.data = dec.store_data;

	assign redirect   = jump & active;

endmodule

// ==== hw/idu.sv ====
// decode unit: instruction classification, immediates, operand select and register file
`include "core_cfg.svh"

module idu import core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [31:0]           inst,
	input  logic [`CORE_XLEN-1:0] pc,
	input  wb_t                   wr,
	output dec_to_exu_t           dec,
	output logic                  is_ebreak
);

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b001_0011,
		OPC_LUI    = 7'b011_0111,
		OPC_AUIPC  = 7'b001_0111,
		OPC_JAL    = 7'b110_1111,
		OPC_JALR   = 7'b110_0111,
		OPC_STORE  = 7'b010_0011,
		OPC_SYSTEM = 7'b111_0011
	} opcode_e;

	localparam logic [31:0] EBREAK_INST = 32'h0010_0073;

	opcode_e                 opcode;
	logic [2:0]              funct3;
	logic [`CORE_REG_AW-1:0] rs1;
	logic [`CORE_REG_AW-1:0] rs2;
	logic [`CORE_XLEN-1:0]   imm_i;
	logic [`CORE_XLEN-1:0]   imm_u;
	logic [`CORE_XLEN-1:0]   imm_j;
	logic [`CORE_XLEN-1:0]   imm_s;
	logic [`CORE_XLEN-1:0]   imm;
	logic [`CORE_XLEN-1:0]   rdata1;
	logic [`CORE_XLEN-1:0]   rdata2;
	logic [`CORE_XLEN-1:0]   src1;
	inst_class_e             cls;
	wb_t                     rf_wr;

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	// immediate formats
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

	always_comb begin
		cls = CLS_NONE;
		case (opcode)
			OPC_OP_IMM: begin
				if (funct3 == 3'b000) begin
					cls = CLS_ADDI;
				end
			end
			OPC_LUI:   cls = CLS_LUI;
			OPC_AUIPC: cls = CLS_AUIPC;
			OPC_JAL:   cls = CLS_JAL;
			OPC_JALR: begin
				if (funct3 == 3'b000) begin
					cls = CLS_JALR;
				end
			end
			OPC_STORE: begin
				// only word stores
				if (funct3 == 3'b010) begin
					cls = CLS_SW;
				end
			end
			OPC_SYSTEM: begin
				// whole word must match
				if (inst == EBREAK_INST) begin
					cls = CLS_EBREAK;
				end
			end
			default: cls = CLS_NONE;
		endcase
	end

	always_comb begin
		case (cls)
			CLS_LUI, CLS_AUIPC: imm = imm_u;
			CLS_JAL:            imm = imm_j;
			CLS_SW:             imm = imm_s;
			default:            imm = imm_i;
		endcase
	end

	// pc relative forms take pc, lui adds to zero
	always_comb begin
		case (cls)
			CLS_JAL, CLS_AUIPC: src1 = pc;
			CLS_LUI:            src1 = '0;
			default:            src1 = rdata1;
		endcase
	end

	// no register updates while in reset
	always_comb begin
		rf_wr    = wr;
		rf_wr.en = wr.en & rst_n;
	end

	regfile u_regfile (
		.clk    (clk),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.wr     (rf_wr)
	);

	assign dec.cls        = cls;
	assign dec.op         = ALU_ADD;
	assign dec.pc         = pc;
	assign dec.src1       = src1;
	assign dec.src2       = (cls == CLS_NONE) ? rdata2 : imm;
	assign dec.store_data = rdata2;
	assign dec.rd         = inst[11:7];

	assign is_ebreak = (cls == CLS_EBREAK);

endmodule

// ==== hw/regfile.sv ====
// register file: 32 entries, two combinational reads, one clocked write, x0 tied to zero
`include "core_cfg.svh"

module regfile import core_pkg::*; (
	input  logic                    clk,
	input  logic [`CORE_REG_AW-1:0] raddr1,
	input  logic [`CORE_REG_AW-1:0] raddr2,
	output logic [`CORE_XLEN-1:0]   rdata1,
	output logic [`CORE_XLEN-1:0]   rdata2,
	input  wb_t                     wr
);

	localparam int NUM_REGS = 1 << `CORE_REG_AW;

	logic [`CORE_XLEN-1:0] regs [NUM_REGS];

	// x0 is never written
	always_ff @(posedge clk) begin
		if (wr.en && (wr.addr != '0)) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// reads of x0 bypass the array
	always_comb begin
		if (raddr1 == '0) begin
			rdata1 = '0;
		end else begin
			rdata1 = regs[raddr1];
		end
		if (raddr2 == '0) begin
			rdata2 = '0;
		end else begin
			rdata2 = regs[raddr2];
		end
	end

endmodule

// ==== hw/ifu.sv ====
// fetch unit: program counter register, next pc selection and halt latch
`include "core_cfg.svh"

module ifu (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  redirect,
	input  logic [`CORE_XLEN-1:0] target,
	input  logic                  is_ebreak,
	output logic [`CORE_XLEN-1:0] pc,
	output logic                  halted
);

	logic [`CORE_XLEN-1:0] pc_seq;
	logic [`CORE_XLEN-1:0] next_pc;

	// sequential step to the following word
	assign pc_seq = pc + `CORE_XLEN'(`CORE_INST_BYTES);

	// jumps win over the sequential path
	always_comb begin
		if (redirect) begin
			next_pc = target;
		end else begin
			next_pc = pc_seq;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc     <= `CORE_RESET_PC;
			halted <= 1'b0;
		end else if (!halted) begin
			if (is_ebreak) begin
				// pc stays on the ebreak itself
				halted <= 1'b1;
			end else begin
				pc <= next_pc;
			end
		end
	end

endmodule

// ==== hw/core_pkg.sv ====
// core package: instruction class enum, alu op enum, decode, writeback and store structs
`include "core_cfg.svh"

package core_pkg;

	// instruction classes the decoder can recognise
	typedef enum logic [3:0] {
		CLS_ADDI,
		CLS_LUI,
		CLS_AUIPC,
		CLS_JAL,
		CLS_JALR,
		CLS_SW,
		CLS_EBREAK,
		CLS_NONE
	} inst_class_e;

	// alu function, same width as the decoder op field
	typedef enum logic [2:0] {
		ALU_ADD = 3'b000
	} alu_op_e;

	// decode to execute bundle
	typedef struct packed {
		inst_class_e             cls;
		alu_op_e                 op;
		logic [`CORE_XLEN-1:0]   pc;
		logic [`CORE_XLEN-1:0]   src1;
		logic [`CORE_XLEN-1:0]   src2;
		// raw rs2 value for stores
		logic [`CORE_XLEN-1:0]   store_data;
		logic [`CORE_REG_AW-1:0] rd;
	} dec_to_exu_t;

	// register write port
	typedef struct packed {
		logic                    en;
		logic [`CORE_REG_AW-1:0] addr;
		logic [`CORE_XLEN-1:0]   data;
	} wb_t;

	// store port toward the external memory
	typedef struct packed {
		logic                  en;
		logic [`CORE_XLEN-1:0] addr;
		logic [`CORE_XLEN-1:0] data;
	} store_t;

endpackage

// ==== hw/core_cfg.svh ====
// core configuration macros: data width, register address width and reset pc
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path and program counter width
`define CORE_XLEN 32

// register file address width, 32 architectural registers
`define CORE_REG_AW 5

// first fetch address after reset
`define CORE_RESET_PC 32'h8000_0000

// fixed instruction size in bytes, used for the sequential pc step
`define CORE_INST_BYTES 4

`endif
